// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := pwm_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/pwm_pkg.sv
package pwm_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus widths and field types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SIZE_W = 3;

    // d-side codes sit off the a-side values so one enum holds both
    typedef enum logic [2:0] {
        TL_PUT_FULL = 3'd0,
        TL_PUT_PART = 3'd1,
        TL_GET      = 3'd4,
        TL_ACK      = 3'd6,
        TL_ACK_DATA = 3'd7
    } tl_opcode_e;

    localparam logic [SIZE_W-1:0] TL_SIZE_4B = SIZE_W'(2);  // log2 of byte count

    typedef struct packed {
        tl_opcode_e          opcode;
        logic [ADDR_W-1:0]   address;
        logic [DATA_W-1:0]   data;
    } tl_a_t;

    typedef struct packed {
        tl_opcode_e          opcode;
        logic [SIZE_W-1:0]   size;
        logic [DATA_W-1:0]   data;
    } tl_d_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register map, offsets inside the window
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [7:0] WINDOW_MASK = 8'hFF;

    localparam logic [7:0] CTRL_1     = 8'h00;
    localparam logic [7:0] CTRL_2     = 8'h04;
    localparam logic [7:0] PERIOD_1   = 8'h08;
    localparam logic [7:0] PERIOD_2   = 8'h0C;
    localparam logic [7:0] THRSLD_1_1 = 8'h10;  // channel 1, low threshold
    localparam logic [7:0] THRSLD_1_2 = 8'h14;  // channel 1, high threshold
    localparam logic [7:0] THRSLD_2_1 = 8'h18;
    localparam logic [7:0] THRSLD_2_2 = 8'h1C;
    localparam logic [7:0] STEP_1     = 8'h20;
    localparam logic [7:0] STEP_2     = 8'h24;
    localparam logic [7:0] OUT_1      = 8'h28;  // read only
    localparam logic [7:0] OUT_2      = 8'h2C;

    // control register bits
    localparam int CTRL_EN_BIT   = 0;
    localparam int CTRL_MODE_BIT = 1;

    typedef enum logic {
        MODE_EDGE = 1'b0,  // high while counter below threshold_lo
        MODE_BAND = 1'b1   // high between the two thresholds
    } pwm_mode_e;

    // one channel's configuration as seen by the generator
    typedef struct packed {
        logic                enable;
        pwm_mode_e           mode;
        logic [DATA_W-1:0]   period;
        logic [DATA_W-1:0]   threshold_lo;
        logic [DATA_W-1:0]   threshold_hi;
        logic [DATA_W-1:0]   step;
    } pwm_cfg_t;

endpackage

// File: hdl/pwm_top.sv
`timescale 1ns/1ps

module pwm_top
    import pwm_pkg::*;
#(
    parameter logic [ADDR_W-1:0] BASE_ADDR = 32'h4000_0000
) (
    input  logic        clk_i,
    input  logic        rstn_i,

    // bus request
    input  tl_a_t       req_i,
    input  logic        req_valid_i,
    output logic        req_ready_o,

    // bus response
    output tl_d_t       rsp_o,
    output logic        rsp_valid_o,
    input  logic        rsp_ready_i,

    output logic [1:0]  pwm_o
);

    pwm_cfg_t cfg_1;
    pwm_cfg_t cfg_2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register block
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    pwm_regs #(
        .BASE_ADDR      (BASE_ADDR)
    ) pwm_regs_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .req_i          (req_i),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .rsp_o          (rsp_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_ready_i    (rsp_ready_i),
        .pwm_i          (pwm_o),         // live outputs for read-back
        .cfg_1_o        (cfg_1),
        .cfg_2_o        (cfg_2)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // generators
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    pwm_channel pwm_channel_1_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .cfg_i          (cfg_1),
        .pwm_o          (pwm_o[0])
    );

    pwm_channel pwm_channel_2_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .cfg_i          (cfg_2),
        .pwm_o          (pwm_o[1])
    );

endmodule

// File: list.f
common/pwm_pkg.sv
pwm/pwm_channel.sv
pwm/pwm_regs.sv
hdl/pwm_top.sv
sim/pwm_clk_gen.sv
sim/pwm_tb.sv

// File: pwm/pwm_channel.sv
`timescale 1ns/1ps

module pwm_channel
    import pwm_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,

    input  pwm_cfg_t    cfg_i,
    output logic        pwm_o
);

    logic [DATA_W-1:0]  count_q;
    logic [DATA_W-1:0]  count_d;
    logic [DATA_W:0]    sum;        // one extra bit so a large step cannot wrap
    logic               in_edge;
    logic               in_band;
    logic               pwm_d;
    logic               pwm_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // step counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign sum = {1'b0, count_q} + {1'b0, cfg_i.step};

    always_comb begin
        if (!cfg_i.enable) begin
            count_d = '0;
        end else if (sum >= {1'b0, cfg_i.period}) begin
            count_d = '0;  // wrap, zero period also lands here
        end else begin
            count_d = sum[DATA_W-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare and output
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign in_edge = count_q < cfg_i.threshold_lo;
    assign in_band = (count_q >= cfg_i.threshold_lo) && (count_q < cfg_i.threshold_hi);

    always_comb begin
        if (!cfg_i.enable || (cfg_i.period == '0)) begin
            pwm_d = 1'b0;
        end else begin
            case (cfg_i.mode)
                MODE_EDGE: pwm_d = in_edge;
                MODE_BAND: pwm_d = in_band;
                default:   pwm_d = 1'b0;
            endcase
        end
    end

    // output follows the counter by one cycle
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            pwm_q <= 1'b0;
        end else begin
            pwm_q <= pwm_d;
        end
    end

    assign pwm_o = pwm_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // assertions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a freshly lowered period gets one cycle to pull the counter back in
    a_count_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (cfg_i.period != '0) && $stable(cfg_i.period) |-> count_q < cfg_i.period)
        else $error("counter at or above period");

endmodule

// File: pwm/pwm_regs.sv
`timescale 1ns/1ps

module pwm_regs
    import pwm_pkg::*;
#(
    parameter logic [ADDR_W-1:0] BASE_ADDR = 32'h4000_0000
) (
    input  logic        clk_i,
    input  logic        rstn_i,

    // a channel
    input  tl_a_t       req_i,
    input  logic        req_valid_i,
    output logic        req_ready_o,

    // d channel
    output tl_d_t       rsp_o,
    output logic        rsp_valid_o,
    input  logic        rsp_ready_i,

    input  logic [1:0]  pwm_i,
    output pwm_cfg_t    cfg_1_o,
    output pwm_cfg_t    cfg_2_o
);

    logic               rsp_valid_q;
    tl_d_t              rsp_q;
    pwm_cfg_t           cfg_1_q;
    pwm_cfg_t           cfg_2_q;

    logic               take;
    logic               in_window;
    logic               hit;
    logic               is_read;
    logic               is_write;
    logic [7:0]         offset;
    logic [DATA_W-1:0]  rd_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // free when nothing waits, or the waiting response leaves this cycle
    assign req_ready_o = !rsp_valid_q || rsp_ready_i;
    assign take        = req_valid_i && req_ready_o;

    assign in_window = (req_i.address & ~ADDR_W'(WINDOW_MASK)) == BASE_ADDR;
    assign hit       = take && in_window;  // outside the window: taken, ignored
    assign offset    = req_i.address[7:0] & WINDOW_MASK;

    assign is_read  = req_i.opcode == TL_GET;
    assign is_write = (req_i.opcode == TL_PUT_FULL) || (req_i.opcode == TL_PUT_PART);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // configuration registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // byte mask ignored, every put is a full word
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cfg_1_q <= '0;
            cfg_2_q <= '0;
        end else if (hit && is_write) begin
            case (offset)
                CTRL_1: begin
                    cfg_1_q.enable <= req_i.data[CTRL_EN_BIT];
                    cfg_1_q.mode   <= pwm_mode_e'(req_i.data[CTRL_MODE_BIT]);
                end
                CTRL_2: begin
                    cfg_2_q.enable <= req_i.data[CTRL_EN_BIT];
                    cfg_2_q.mode   <= pwm_mode_e'(req_i.data[CTRL_MODE_BIT]);
                end
                PERIOD_1:   cfg_1_q.period       <= req_i.data;
                PERIOD_2:   cfg_2_q.period       <= req_i.data;
                THRSLD_1_1: cfg_1_q.threshold_lo <= req_i.data;
                THRSLD_1_2: cfg_1_q.threshold_hi <= req_i.data;
                THRSLD_2_1: cfg_2_q.threshold_lo <= req_i.data;
                THRSLD_2_2: cfg_2_q.threshold_hi <= req_i.data;
                STEP_1:     cfg_1_q.step         <= req_i.data;
                STEP_2:     cfg_2_q.step         <= req_i.data;
                default: ;  // unmapped or read-only, nothing stored
            endcase
        end
    end

    assign cfg_1_o = cfg_1_q;
    assign cfg_2_o = cfg_2_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // only the live outputs read back
    always_comb begin
        case (offset)
            OUT_1:   rd_data = DATA_W'(pwm_i[0]);
            OUT_2:   rd_data = DATA_W'(pwm_i[1]);
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rsp_valid_q <= 1'b0;
        end else if (hit) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // loaded only on a hit, so it holds through a stall
    always_ff @(posedge clk_i) begin
        if (hit) begin
            rsp_q.opcode <= is_read ? TL_ACK_DATA : TL_ACK;
            rsp_q.size   <= TL_SIZE_4B;
            rsp_q.data   <= is_read ? rd_data : '0;
        end
    end

    assign rsp_o       = rsp_q;
    assign rsp_valid_o = rsp_valid_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // assertions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a stalled response stays put until the master takes it
    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
        else $error("response changed while stalled");

endmodule

// File: sim/pwm_clk_gen.sv
`timescale 1ns/1ps

module pwm_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset leaves 1 ns after an edge, like the other inputs
    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rstn_o = 1'b1;
    end

endmodule

// File: sim/pwm_tb.sv
`timescale 1ns/1ps

module pwm_tb
    import pwm_pkg::*;
();

    localparam logic [31:0] BASE_ADDR = 32'h4000_0000;
    localparam int CLK_NS   = 20;
    localparam int HS_LIMIT = 64;     // cycles a request may wait for ready

    // cycle budget per test, the watchdog allows their sum plus a margin
    localparam int WATCHDOG_CYCLES = 40 + 150 + 400 + 1000 + 400 + 150 + 500;

    logic        clk_i;
    logic        rstn_i;
    tl_a_t       req_i;
    logic        req_valid_i;
    logic        req_ready_o;
    tl_d_t       rsp_o;
    logic        rsp_valid_o;
    logic        rsp_ready_i;
    logic [1:0]  pwm_o;
    logic        stall_en;

    int errors;
    int errors_seen;
    int tests_run;
    int tests_failed;

    pwm_clk_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(16)) pwm_clk_gen_inst (
        .clk_o  (clk_i),
        .rstn_o (rstn_i)
    );

    pwm_top #(
        .BASE_ADDR      (BASE_ADDR)
    ) pwm_top_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .req_i          (req_i),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .rsp_o          (rsp_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_ready_i    (rsp_ready_i),
        .pwm_o          (pwm_o)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    pwm_cfg_t    m_cfg [2];
    logic [31:0] m_count [2];
    logic [1:0]  m_pwm;
    logic        m_rsp_valid;
    tl_opcode_e  m_rsp_op;
    logic [31:0] m_rsp_data;

    logic        m_ready;
    logic        m_take;
    logic        m_in_win;
    logic        m_hit;
    logic        m_is_read;
    logic        m_is_write;
    logic [7:0]  m_offset;

    assign m_ready    = !m_rsp_valid || rsp_ready_i;
    assign m_take     = req_valid_i && m_ready;
    assign m_in_win   = req_i.address[31:8] == BASE_ADDR[31:8];
    assign m_hit      = m_take && m_in_win;
    assign m_offset   = req_i.address[7:0];
    assign m_is_read  = req_i.opcode == TL_GET;
    assign m_is_write = (req_i.opcode == TL_PUT_FULL) || (req_i.opcode == TL_PUT_PART);

    function automatic logic [31:0] next_count(input pwm_cfg_t cfg, input logic [31:0] count);
        logic [32:0] sum;
        sum = {1'b0, count} + {1'b0, cfg.step};
        if (!cfg.enable || (sum >= {1'b0, cfg.period})) return '0;
        return sum[31:0];
    endfunction

    function automatic logic next_pwm(input pwm_cfg_t cfg, input logic [31:0] count);
        if (!cfg.enable || (cfg.period == 0)) return 1'b0;
        if (cfg.mode == MODE_BAND) return (count >= cfg.threshold_lo) && (count < cfg.threshold_hi);
        return count < cfg.threshold_lo;
    endfunction

    always @(posedge clk_i) begin
        if (!rstn_i) begin
            m_rsp_valid <= 1'b0;
            m_rsp_op    <= TL_ACK;
            m_rsp_data  <= '0;
            m_pwm       <= '0;
            for (int c = 0; c < 2; c++) begin
                m_cfg[c]   <= '0;
                m_count[c] <= '0;
            end
        end else begin
            if (m_hit) begin
                m_rsp_valid <= 1'b1;
                m_rsp_op    <= m_is_read ? TL_ACK_DATA : TL_ACK;
                m_rsp_data  <= !m_is_read          ? '0 :
                               (m_offset == OUT_1) ? 32'(m_pwm[0]) :
                               (m_offset == OUT_2) ? 32'(m_pwm[1]) : '0;
            end else if (rsp_ready_i) begin
                m_rsp_valid <= 1'b0;
            end
            if (m_hit && m_is_write) begin
                case (m_offset)
                    CTRL_1: begin
                        m_cfg[0].enable <= req_i.data[0];
                        m_cfg[0].mode   <= pwm_mode_e'(req_i.data[1]);
                    end
                    CTRL_2: begin
                        m_cfg[1].enable <= req_i.data[0];
                        m_cfg[1].mode   <= pwm_mode_e'(req_i.data[1]);
                    end
                    PERIOD_1:   m_cfg[0].period       <= req_i.data;
                    PERIOD_2:   m_cfg[1].period       <= req_i.data;
                    THRSLD_1_1: m_cfg[0].threshold_lo <= req_i.data;
                    THRSLD_1_2: m_cfg[0].threshold_hi <= req_i.data;
                    THRSLD_2_1: m_cfg[1].threshold_lo <= req_i.data;
                    THRSLD_2_2: m_cfg[1].threshold_hi <= req_i.data;
                    STEP_1:     m_cfg[0].step         <= req_i.data;
                    STEP_2:     m_cfg[1].step         <= req_i.data;
                    default: ;
                endcase
            end
            for (int c = 0; c < 2; c++) begin
                m_count[c] <= next_count(m_cfg[c], m_count[c]);
                m_pwm[c]   <= next_pwm(m_cfg[c], m_count[c]);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic note_mismatch(input string msg);
        errors++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    a_reset_state: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> !rsp_valid_o && (pwm_o == 2'b00) && req_ready_o)
        else note_mismatch("state after reset is not idle");

    a_ready: assert property (@(posedge clk_i) disable iff (!rstn_i)
        req_ready_o == m_ready)
        else note_mismatch("req_ready_o differs from model");

    a_rsp_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o == m_rsp_valid)
        else note_mismatch("rsp_valid_o differs from model");

    a_rsp_opcode: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o |-> rsp_o.opcode == m_rsp_op)
        else note_mismatch("response opcode differs from model");

    a_rsp_size: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o |-> rsp_o.size == 3'd2)  // 4 bytes
        else note_mismatch("response size is not 4 bytes");

    a_rsp_data: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o && (m_rsp_op == TL_ACK_DATA) |-> rsp_o.data == m_rsp_data)
        else note_mismatch("read data differs from model");

    a_stall_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
        else note_mismatch("response moved while stalled");

    a_stall_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o && !rsp_ready_i |-> !req_ready_o)
        else note_mismatch("request ready while a response is stalled");

    a_pwm_1: assert property (@(posedge clk_i) disable iff (!rstn_i) pwm_o[0] == m_pwm[0])
        else note_mismatch("pwm_o[0] differs from model");

    a_pwm_2: assert property (@(posedge clk_i) disable iff (!rstn_i) pwm_o[1] == m_pwm[1])
        else note_mismatch("pwm_o[1] differs from model");

    a_disable_low_1: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !m_cfg[0].enable |=> !pwm_o[0])
        else note_mismatch("pwm_o[0] high after enable cleared");

    a_disable_low_2: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !m_cfg[1].enable |=> !pwm_o[1])
        else note_mismatch("pwm_o[1] high after enable cleared");

    a_readback_1: assert property (@(posedge clk_i) disable iff (!rstn_i)
        m_hit && m_is_read && (m_offset == OUT_1) |=> rsp_o.data == 32'($past(pwm_o[0])))
        else note_mismatch("OUT_1 read does not match pwm_o[0] at the taking edge");

    a_readback_2: assert property (@(posedge clk_i) disable iff (!rstn_i)
        m_hit && m_is_read && (m_offset == OUT_2) |=> rsp_o.data == 32'($past(pwm_o[1])))
        else note_mismatch("OUT_2 read does not match pwm_o[1] at the taking edge");

    a_outside_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i)
        m_take && !m_in_win |=> !rsp_valid_o)
        else note_mismatch("request outside the window got a response");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic bus_op(input tl_opcode_e op, input logic [31:0] addr, input logic [31:0] data);
        int waited;
        waited = 0;
        @(posedge clk_i);
        #1;
        req_i.opcode  = op;
        req_i.address = addr;
        req_i.data    = data;
        req_valid_i   = 1'b1;
        @(negedge clk_i);  // ready is settled mid cycle
        while (!req_ready_o && (waited < HS_LIMIT)) begin
            @(negedge clk_i);
            waited++;
        end
        if (!req_ready_o) begin
            errors++;
            $display("request to %h was not accepted within %0d cycles", addr, HS_LIMIT);
        end
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] offset, input logic [31:0] data);
        bus_op(TL_PUT_FULL, BASE_ADDR | 32'(offset), data);
    endtask

    task automatic read_reg(input logic [7:0] offset);
        bus_op(TL_GET, BASE_ADDR | 32'(offset), '0);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk_i);
    endtask

    task automatic drive_rsp_ready();
        forever begin
            @(posedge clk_i);
            #1;
            rsp_ready_i = stall_en ? ($urandom_range(3, 0) != 0) : 1'b1;
        end
    endtask

    task automatic random_channel(input int ch, input logic band);
        logic [31:0] period;
        logic [31:0] lo;
        logic [31:0] hi;
        period = $urandom_range(200, 20);
        lo     = band ? $urandom_range(period / 2, 0) : $urandom_range(period, 0);
        hi     = $urandom_range(period, lo);
        write_reg(ch == 0 ? PERIOD_1 : PERIOD_2, period);
        write_reg(ch == 0 ? THRSLD_1_1 : THRSLD_2_1, lo);
        write_reg(ch == 0 ? THRSLD_1_2 : THRSLD_2_2, hi);
        write_reg(ch == 0 ? STEP_1 : STEP_2, $urandom_range(7, 1));
        write_reg(ch == 0 ? CTRL_1 : CTRL_2, {30'b0, band, 1'b1});
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - errors_seen;
        tests_run++;
        if (n != 0) tests_failed++;
        errors_seen = errors;
        $display("test %0d %-18s %s, %0d check(s) failed", tests_run, name,
                 (n == 0) ? "ok" : "FAILED", n);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        void'($urandom(32'h9220));
        req_i        = '0;
        req_valid_i  = 1'b0;
        rsp_ready_i  = 1'b1;
        stall_en     = 1'b0;
        errors       = 0;
        errors_seen  = 0;
        tests_run    = 0;
        tests_failed = 0;
        fork
            drive_rsp_ready();
        join_none

        wait (rstn_i === 1'b1);
        idle(4);
        end_test("reset state");

        // every register once, channels left disabled
        write_reg(CTRL_1, 32'h0);
        write_reg(CTRL_2, 32'h0);
        for (int i = 2; i < 10; i++) write_reg(8'(4 * i), $urandom);
        bus_op(TL_PUT_PART, BASE_ADDR | 32'(STEP_1), 32'd3);
        bus_op(TL_ACK, BASE_ADDR | 32'(CTRL_1), 32'd3);  // bogus opcode, nothing stored
        read_reg(CTRL_1);
        read_reg(8'h30);
        read_reg(OUT_1);
        read_reg(OUT_2);
        idle(4);
        end_test("response timing");

        stall_en = 1'b1;
        for (int i = 0; i < 40; i++) begin
            if ($urandom_range(1, 0) != 0) begin
                write_reg(THRSLD_1_1 + 8'(4 * $urandom_range(3, 0)), $urandom);
            end else begin
                read_reg(OUT_1 + 8'(4 * $urandom_range(1, 0)));
            end
        end
        stall_en = 1'b0;
        idle(4);
        end_test("back-pressure");

        stall_en = 1'b1;
        random_channel(0, 1'b0);
        random_channel(1, 1'b0);
        idle(300);
        random_channel(0, 1'b1);
        random_channel(1, 1'b1);
        idle(300);
        write_reg(CTRL_1, 32'h0);
        write_reg(CTRL_2, 32'h0);
        idle(10);
        stall_en = 1'b0;
        end_test("edge and band");

        stall_en = 1'b1;
        random_channel(0, 1'b0);
        random_channel(1, 1'b1);
        for (int i = 0; i < 30; i++) begin
            read_reg(OUT_1 + 8'(4 * $urandom_range(1, 0)));
            idle($urandom_range(3, 0));
        end
        stall_en = 1'b0;
        idle(4);
        end_test("output read-back");

        // channels still running, these must not stop them
        bus_op(TL_PUT_FULL, (BASE_ADDR + 32'h100) | 32'(CTRL_1), 32'h0);
        bus_op(TL_PUT_FULL, (BASE_ADDR - 32'h100) | 32'(CTRL_2), 32'h0);
        bus_op(TL_GET, (BASE_ADDR + 32'h200) | 32'(OUT_1), 32'h0);
        idle(50);
        end_test("outside window");

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_NS);
        $display("watchdog expired at %0t, the tests did not finish", $time);
        $display("Test failed");
        $finish;
    end

endmodule
